//--- flist.f
hw/cb_pkg.sv
hw/completion_buffer.sv
hw/alu_unit.sv
hw/mul_unit.sv
hw/reg_file.sv
hw/ooo_backend_top.sv
dv/cb_checker.sv
dv/ooo_backend_tb.sv

//--- Bender.yml
package:
  name: ooo_backend

sources:
  - files:
      - hw/cb_pkg.sv
      - hw/completion_buffer.sv
      - hw/alu_unit.sv
      - hw/mul_unit.sv
      - hw/reg_file.sv
      - hw/ooo_backend_top.sv
  - target: test
    files:
      - dv/cb_checker.sv
      - dv/ooo_backend_tb.sv

//--- dv/ooo_backend_tb.sv
`timescale 1ns/1ps

module ooo_backend_tb import cb_pkg::*; ();

  // Four slots, fewer than a multiply round trip, so back-to-back MULs fill the buffer
  localparam int NUM_ENTRY = 4;
  localparam int TIMEOUT   = 200;
  localparam int NUM_ROWS  = 21;
  localparam int SEL_FULL  = 0;
  localparam int SEL_EMPTY = 1;
  localparam int SEL_FLUSH = 2;

  // Rows 0-7 mixed order, 8-11 fill, 12-16 exception, 17-20 restart
  localparam op_e ROW_OP [NUM_ROWS] = '{
    OP_MUL, OP_ADD, OP_SUB, OP_MUL, OP_AND, OP_XOR, OP_SLT, OP_ADD,
    OP_MUL, OP_MUL, OP_MUL, OP_MUL,
    OP_ADD, OP_MUL, OP_ILL, OP_ADD, OP_MUL,
    OP_SUB, OP_MUL, OP_SLT, OP_XOR};
  localparam int ROW_RD [NUM_ROWS] = '{
    1, 2, 3, 4, 5, 1, 7, 0, 8, 9, 10, 11, 16, 17, 18, 19, 20, 21, 22, 23, 24};

  logic      CLK = 1'b0;
  logic      nRST;
  logic      dispatch_valid;
  dispatch_t dispatch;
  logic      full, empty, commit_valid, flush;
  commit_t   commit;
  reg_addr_t exception_rd, rf_raddr;
  word_t     rf_rdata;

  dispatch_t stim [NUM_ROWS];
  commit_t   exp_q [$];
  commit_t   want;
  word_t     rf_model [32];
  integer    seed;
  int        errors, checks, tests, err_mark, commit_cnt, cnt0;
  int        occ, occ_next;
  logic      room = 1'b1;

  ooo_backend_top #(.NUM_ENTRY (NUM_ENTRY)) dut_i (
    .CLK, .nRST, .dispatch_valid, .dispatch, .full, .empty, .commit_valid,
    .flush, .commit, .exception_rd, .rf_raddr, .rf_rdata
  );

  always #50 CLK = ~CLK;

  // Expected result from the opcode rules
  function automatic word_t ref_result(input dispatch_t d);
    case (d.op)
      OP_ADD:  return d.a + d.b;
      OP_SUB:  return d.a - d.b;
      OP_AND:  return d.a & d.b;
      OP_XOR:  return d.a ^ d.b;
      OP_SLT:  return ($signed(d.a) < $signed(d.b)) ? 32'd1 : 32'd0;
      OP_MUL:  return d.a * d.b;
      default: return '0;
    endcase
  endfunction

  function automatic logic probe(input int sel);
    case (sel)
      SEL_FULL:  return full;
      SEL_EMPTY: return empty;
      default:   return flush;
    endcase
  endfunction

  task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error: %s got 0x%0h, expected 0x%0h", name, got, exp);
    end
  endtask

  task automatic finish_run();
    $display("Summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  endtask

  task automatic wait_until(input int sel, input logic level, input string what);
    int n;
    n = 0;
    do begin
      @(negedge CLK);
      n++;
    end while (probe(sel) !== level && n < TIMEOUT);
    if (probe(sel) !== level) begin
      errors++;
      $display("Timeout: %s did not happen within %0d cycles", what, TIMEOUT);
      finish_run();
    end
  endtask

  // Drive one op on the first edge with a free slot and queue its commit
  task automatic issue_op(input dispatch_t d, input bit retires);
    int      n;
    commit_t c;
    n = 0;
    @(posedge CLK);
    while (!room && n < TIMEOUT) begin
      dispatch_valid <= 1'b0;
      n++;
      @(posedge CLK);
    end
    if (!room) begin
      errors++;
      $display("Timeout: no free buffer slot for rd %0d", d.rd);
      finish_run();
    end else begin
      dispatch_valid <= 1'b1;
      dispatch       <= d;
      if (retires) begin
        c.rd   = d.rd;
        c.data = ref_result(d);
        exp_q.push_back(c);
        if (d.rd != 0) rf_model[d.rd] = c.data;
      end
    end
  endtask

  // Everything from an illegal op onwards gets flushed
  task automatic run_rows(input int first, input int last);
    bit killed;
    killed = 1'b0;
    for (int i = first; i <= last; i++) begin
      if (stim[i].op == OP_ILL) killed = 1'b1;
      issue_op(stim[i], !killed);
    end
    @(posedge CLK);
    dispatch_valid <= 1'b0;
  endtask

  task automatic drain(input string name);
    wait_until(SEL_EMPTY, 1'b1, "empty");
    check_value("pending commits", exp_q.size(), 0);
    $display("%s: %0d errors", name, errors - err_mark);
    tests++;
    err_mark = errors;
  endtask

  // Scoreboard and occupancy model, sampled mid-cycle
  always @(negedge CLK) begin
    if (nRST) begin
      check_value("full", full, occ == NUM_ENTRY);
      check_value("empty", empty, occ == 0);
      if (commit_valid) begin
        if (exp_q.size() == 0) begin
          errors++;
          $display("Commit to rd %0d with no operation left to retire", commit.rd);
        end else begin
          want = exp_q.pop_front();
          check_value("commit.rd", commit.rd, want.rd);
          check_value("commit.data", commit.data, want.data);
        end
        commit_cnt <= commit_cnt + 1;
      end
      // Occupancy after the coming edge decides whether the next dispatch may go
      occ_next = flush ? 0 : occ + ((dispatch_valid && !full) ? 1 : 0) - (commit_valid ? 1 : 0);
      occ  <= occ_next;
      room <= (occ_next < NUM_ENTRY);
    end
  end

  initial begin
    nRST           = 1'b0;
    dispatch_valid = 1'b0;
    dispatch       = '0;
    rf_raddr       = '0;
    seed           = 32'hb1c6_0084;
    for (int r = 0; r < 32; r++) rf_model[r] = '0;
    for (int i = 0; i < NUM_ROWS; i++) begin
      stim[i].op = ROW_OP[i];
      stim[i].rd = reg_addr_t'(ROW_RD[i]);
      stim[i].a  = $random(seed);
      stim[i].b  = $random(seed);
    end
    repeat (8) @(posedge CLK);
    nRST <= 1'b1;

    run_rows(0, 7);
    drain("mixed ALU and MUL order");

    // Register file holds the last committed values
    for (int r = 0; r < 8; r++) begin
      @(posedge CLK);
      rf_raddr <= reg_addr_t'(r);
      @(negedge CLK);
      check_value($sformatf("rf_rdata[%0d]", r), rf_rdata, rf_model[r]);
    end
    $display("register readback: %0d errors", errors - err_mark);
    tests++;
    err_mark = errors;

    run_rows(8, 11);
    wait_until(SEL_FULL, 1'b1, "full rising");
    cnt0 = commit_cnt;
    wait_until(SEL_FULL, 1'b0, "full falling");
    check_value("commit before full fell", commit_cnt > cnt0, 1);
    drain("buffer full");

    run_rows(12, 16);
    wait_until(SEL_FLUSH, 1'b1, "flush");
    check_value("exception_rd", exception_rd, ROW_RD[14]);
    check_value("older commits at flush", exp_q.size(), 0);
    repeat (4) @(negedge CLK);
    drain("exception flush");

    run_rows(17, 20);
    drain("restart after flush");
    finish_run();
  end

endmodule

//--- dv/cb_checker.sv
`timescale 1ns/1ps

module cb_checker import cb_pkg::*; #(
  parameter int NUM_ENTRY = 8
) (
  input logic                  CLK,
  input logic                  nRST,
  input logic                  alloc,
  input logic [CB_IDX_MAX-1:0] cur_tail,
  input logic [NUM_ENTRY-1:0]  valid_q,
  input logic                  commit_valid,
  input logic                  flush,
  input logic                  full,
  input logic                  empty
);

  localparam int IDX_W = $clog2(NUM_ENTRY);

  // Wrap bit keeps the two states apart
  a_full_empty: assert property (@(posedge CLK) disable iff (!nRST) !(full && empty))
    else $error("full and empty high together");

  // A faulting head never retires
  a_commit_flush: assert property (@(posedge CLK) disable iff (!nRST) !(commit_valid && flush))
    else $error("commit_valid and flush high together");

  // Dispatcher has to honour full
  a_alloc_full: assert property (@(posedge CLK) disable iff (!nRST) !(alloc && full))
    else $error("alloc seen while full");

  a_flush_empty: assert property (@(posedge CLK) disable iff (!nRST) flush |=> empty)
    else $error("buffer not empty after flush");

  // A new slot never still holds an unretired result
  a_tail_free: assert property (@(posedge CLK) disable iff (!nRST)
    (alloc && !full) |-> !valid_q[cur_tail[IDX_W-1:0]])
    else $error("alloc handed out a slot that is still valid");

endmodule

bind completion_buffer cb_checker #(.NUM_ENTRY (NUM_ENTRY)) chk_i (
  .CLK, .nRST, .alloc, .cur_tail, .valid_q, .commit_valid, .flush, .full, .empty
);

//--- hw/ooo_backend_top.sv
`timescale 1ns/1ps

module ooo_backend_top import cb_pkg::*; #(
  parameter int NUM_ENTRY = 8
) (
  input  logic      CLK,
  input  logic      nRST,
  input  logic      dispatch_valid,
  input  dispatch_t dispatch,
  output logic      full,
  output logic      empty,
  output logic      commit_valid,
  output logic      flush,
  output commit_t   commit,
  output reg_addr_t exception_rd,
  input  reg_addr_t rf_raddr,
  output word_t     rf_rdata
);

  logic [CB_IDX_MAX-1:0] cur_tail;
  logic                  is_mul;
  logic                  issue;
  logic                  alu_start;
  logic                  mul_start;
  logic                  alu_done;
  logic                  mul_done;
  result_t               alu_res;
  result_t               mul_res;

  // Only multiplies go to the multiplier, illegal ops go to the ALU
  assign is_mul    = (dispatch.op == OP_MUL);
  // No slot is handed out while full, so the unit must stay idle too
  assign issue     = dispatch_valid && !full;
  assign alu_start = issue && !is_mul;
  assign mul_start = issue && is_mul;

  completion_buffer #(
    .NUM_ENTRY (NUM_ENTRY)
  ) cb_i (
    .CLK, .nRST,
    .alloc (dispatch_valid), .cur_tail,
    .alu_done, .alu_res, .mul_done, .mul_res,
    .commit_valid, .commit, .flush, .exception_rd,
    .full, .empty
  );

  alu_unit alu_i (
    .CLK, .nRST,
    .start (alu_start), .op (dispatch), .index (cur_tail),
    .flush, .done (alu_done), .res (alu_res)
  );

  mul_unit mul_i (
    .CLK, .nRST,
    .start (mul_start), .op (dispatch), .index (cur_tail),
    .flush, .done (mul_done), .res (mul_res)
  );

  // Register file is written only by retiring entries
  reg_file rf_i (
    .CLK, .nRST,
    .wen (commit_valid), .wdata (commit),
    .raddr (rf_raddr), .rdata (rf_rdata)
  );

endmodule

//--- hw/reg_file.sv
`timescale 1ns/1ps

module reg_file import cb_pkg::*; (
  input  logic      CLK,
  input  logic      nRST,
  input  logic      wen,
  input  commit_t   wdata,
  input  reg_addr_t raddr,
  output word_t     rdata
);

  // x0 has no storage
  word_t regs_q [1:31];

  // Commit port, writes to x0 are discarded
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      for (int i = 1; i < 32; i++) begin
        regs_q[i] <= '0;
      end
    end else if (wen && (wdata.rd != '0)) begin
      regs_q[wdata.rd] <= wdata.data;
    end
  end

  // Asynchronous read
  always_comb begin
    if (raddr == '0) begin
      rdata = '0;
    end else begin
      rdata = regs_q[raddr];
    end
  end

endmodule

//--- hw/mul_unit.sv
`timescale 1ns/1ps

module mul_unit import cb_pkg::*; (
  input  logic                  CLK,
  input  logic                  nRST,
  input  logic                  start,
  input  dispatch_t             op,
  input  logic [CB_IDX_MAX-1:0] index,
  input  logic                  flush,
  output logic                  done,
  output result_t               res
);

  // Slot and destination follow the operation down the pipe
  typedef struct packed {
    logic [CB_IDX_MAX-1:0] index;
    reg_addr_t             rd;
  } tag_t;

  logic        s1_valid;
  tag_t        s1_tag;
  word_t       s1_pp_lo;
  logic [15:0] s1_pp_hi;
  logic        s2_valid;
  tag_t        s2_tag;
  word_t       s2_prod;

  // Valid bits of all three stages, emptied by a flush
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      s1_valid <= 1'b0;
      s2_valid <= 1'b0;
      done     <= 1'b0;
    end else if (flush) begin
      s1_valid <= 1'b0;
      s2_valid <= 1'b0;
      done     <= 1'b0;
    end else begin
      s1_valid <= start;
      s2_valid <= s1_valid;
      done     <= s2_valid;
    end
  end

  always_ff @(posedge CLK) begin
    // Stage 1: split b into halves
    // Upper half only reaches bits 31:16, so 16 bits of it are kept
    s1_tag   <= '{index: index, rd: op.rd};
    s1_pp_lo <= op.a * op.b[15:0];
    s1_pp_hi <= op.a[15:0] * op.b[31:16];
    // Stage 2: merge the partial products
    s2_tag   <= s1_tag;
    s2_prod  <= s1_pp_lo + {s1_pp_hi, 16'b0};
    // Stage 3: present the low word of the product
    res.index     <= s2_tag.index;
    res.rd        <= s2_tag.rd;
    res.data      <= s2_prod;
    res.exception <= 1'b0;
  end

endmodule

//--- hw/alu_unit.sv
`timescale 1ns/1ps

module alu_unit import cb_pkg::*; (
  input  logic                  CLK,
  input  logic                  nRST,
  input  logic                  start,
  input  dispatch_t             op,
  input  logic [CB_IDX_MAX-1:0] index,
  input  logic                  flush,
  output logic                  done,
  output result_t               res
);

  result_t res_d;

  // Single-cycle integer datapath
  always_comb begin
    res_d           = '0;
    res_d.index     = index;
    res_d.rd        = op.rd;
    case (op.op)
      OP_ADD: res_d.data = op.a + op.b;
      OP_SUB: res_d.data = op.a - op.b;
      OP_AND: res_d.data = op.a & op.b;
      OP_XOR: res_d.data = op.a ^ op.b;
      // Signed compare, 0 or 1
      OP_SLT: res_d.data = {31'b0, $signed(op.a) < $signed(op.b)};
      default: begin
        // OP_ILL and anything unknown, data stays zero
        res_d.exception = 1'b1;
      end
    endcase
  end

  // Done strobe is control, cancelled by a flush in the same cycle
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      done <= 1'b0;
    end else begin
      done <= start && !flush;
    end
  end

  // Result only loads on a new operation
  always_ff @(posedge CLK) begin
    if (start) begin
      res <= res_d;
    end
  end

endmodule

//--- hw/completion_buffer.sv
`timescale 1ns/1ps

module completion_buffer import cb_pkg::*; #(
  parameter int NUM_ENTRY = 8
) (
  input  logic                  CLK,
  input  logic                  nRST,
  input  logic                  alloc,
  output logic [CB_IDX_MAX-1:0] cur_tail,
  input  logic                  alu_done,
  input  result_t               alu_res,
  input  logic                  mul_done,
  input  result_t               mul_res,
  output logic                  commit_valid,
  output commit_t               commit,
  output logic                  flush,
  output reg_addr_t             exception_rd,
  output logic                  full,
  output logic                  empty
);

  localparam int IDX_W = $clog2(NUM_ENTRY);

  // Slot payload, the valid bits are kept apart
  typedef struct packed {
    logic    exception;
    commit_t wb;
  } entry_t;

  logic [NUM_ENTRY-1:0] valid_q;
  entry_t               entry_q [NUM_ENTRY];

  // Pointers carry one extra wrap bit to tell full from empty
  logic [IDX_W:0]   head_q;
  logic [IDX_W:0]   tail_q;
  logic [IDX_W-1:0] head_idx;
  logic [IDX_W-1:0] tail_idx;
  logic [IDX_W-1:0] alu_idx;
  logic [IDX_W-1:0] mul_idx;
  logic             head_valid;
  entry_t           head_entry;
  logic             do_alloc;

  assign head_idx = head_q[IDX_W-1:0];
  assign tail_idx = tail_q[IDX_W-1:0];
  // Units carry the widest index, keep only what this depth needs
  assign alu_idx  = alu_res.index[IDX_W-1:0];
  assign mul_idx  = mul_res.index[IDX_W-1:0];

  assign cur_tail = CB_IDX_MAX'(tail_idx);

  assign empty = (head_q == tail_q);
  assign full  = (head_idx == tail_idx) && (head_q[IDX_W] != tail_q[IDX_W]);

  // A dispatch while full is simply dropped
  assign do_alloc = alloc && !full;

  assign head_valid = valid_q[head_idx];
  assign head_entry = entry_q[head_idx];

  // Head retires as soon as its result is in
  assign commit_valid = head_valid && !head_entry.exception;
  assign commit       = head_entry.wb;

  // Faulting head kills everything, nothing is retired
  assign flush        = head_valid && head_entry.exception;
  assign exception_rd = head_entry.wb.rd;

  // Head and tail pointers
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      head_q <= '0;
      tail_q <= '0;
    end else if (flush) begin
      head_q <= '0;
      tail_q <= '0;
    end else begin
      if (commit_valid) begin
        head_q <= head_q + 1'b1;
      end
      if (do_alloc) begin
        tail_q <= tail_q + 1'b1;
      end
    end
  end

  // Per-slot valid bits
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      valid_q <= '0;
    end else if (flush) begin
      // Late unit results are dropped along with the rest
      valid_q <= '0;
    end else begin
      // Retiring slot frees up
      if (commit_valid) begin
        valid_q[head_idx] <= 1'b0;
      end
      // Both units may land in the same cycle, slots always differ
      if (alu_done) begin
        valid_q[alu_idx] <= 1'b1;
      end
      if (mul_done) begin
        valid_q[mul_idx] <= 1'b1;
      end
    end
  end

  // Result payload, written at whatever slot the unit reports
  always_ff @(posedge CLK) begin
    if (alu_done) begin
      entry_q[alu_idx].exception <= alu_res.exception;
      entry_q[alu_idx].wb.rd     <= alu_res.rd;
      entry_q[alu_idx].wb.data   <= alu_res.data;
    end
    if (mul_done) begin
      entry_q[mul_idx].exception <= mul_res.exception;
      entry_q[mul_idx].wb.rd     <= mul_res.rd;
      entry_q[mul_idx].wb.data   <= mul_res.data;
    end
  end

endmodule

//--- hw/cb_pkg.sv
package cb_pkg;

  // Datapath word and architectural register index
  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_addr_t;

  // Widest completion-buffer index, enough for 32 entries
  // Smaller buffers only look at the low bits
  localparam int CB_IDX_MAX = 5;

  // Opcodes as seen by the back end
  typedef enum logic [2:0] {
    OP_ADD = 3'd0,
    OP_SUB = 3'd1,
    OP_AND = 3'd2,
    OP_XOR = 3'd3,
    OP_SLT = 3'd4,
    // Low half of the product, handled by the multiplier
    OP_MUL = 3'd5,
    // Reported as an exception when it reaches the head
    OP_ILL = 3'd6
  } op_e;

  // One operation from the dispatcher, operands already read
  typedef struct packed {
    op_e       op;
    reg_addr_t rd;
    word_t     a;
    word_t     b;
  } dispatch_t;

  // Completion of one execution unit, tagged with its buffer slot
  typedef struct packed {
    logic [CB_IDX_MAX-1:0] index;
    reg_addr_t             rd;
    word_t                 data;
    logic                  exception;
  } result_t;

  // Register file write for a retiring entry
  typedef struct packed {
    reg_addr_t rd;
    word_t     data;
  } commit_t;

endpackage
